/* ascii_field_decoder.sv */
// Turns ASCIIized load file characters into type, word and end-of-line tokens
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module ascii_field_decoder (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   in_valid,
  input  wire [`FE_CHAR_W-1:0]  in_char,
  load_token_if.source          tok
);

  // Token contents, packed in the order of the interface fields
  typedef struct packed {
    load_stream_pkg::token_kind_e kind;
    logic [`FE_CHAR_W-1:0]        rtype_char;
    ucode_fmt_pkg::load_word_t    word;
  } token_t;

  ////////////////////////////////////////
  // Character classification
  ////////////////////////////////////////

  logic [`FE_WORD_W-1:0] acc;
  logic                  field_seen;
  logic                  at_line_start;
  logic                  is_blank;
  logic                  is_data;

  assign is_blank = (in_char == `FE_CH_CR) || (in_char == `FE_CH_SPACE);
  // ASCIIized characters run from 075 to 174
  assign is_data  = (in_char >= 7'o075) && (in_char <= 7'o174);

  ////////////////////////////////////////
  // Tokens produced by this character
  ////////////////////////////////////////

  token_t new0;
  token_t new1;
  token_t pend;
  logic   new0_v;
  logic   new1_v;
  logic   pend_v;

  always_comb begin
    new0_v = 1'b0;
    new1_v = 1'b0;
    new0   = '{kind: load_stream_pkg::TOK_WORD, rtype_char: in_char, word: acc};
    new1   = '{kind: load_stream_pkg::TOK_EOL, rtype_char: in_char, word: acc};
    if (in_valid && !is_blank) begin
      if (in_char == `FE_CH_NL) begin
        // Open field goes out first, EOL follows a cycle later
        new0_v = 1'b1;
        if (field_seen) begin
          new1_v = 1'b1;
        end else begin
          new0.kind = load_stream_pkg::TOK_EOL;
        end
      end else if (at_line_start) begin
        new0_v    = 1'b1;
        new0.kind = load_stream_pkg::TOK_TYPE;
      end else if (in_char == `FE_CH_COMMA) begin
        // Comma closes the field, empty means zero
        new0_v = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Field accumulation and token output
  ////////////////////////////////////////

  // A newline after data yields two tokens, the one-entry slot absorbs the
  // extra and drains on the next data character or idle cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc           <= '0;
      field_seen    <= 1'b0;
      at_line_start <= 1'b1;
      pend_v        <= 1'b0;
      tok.valid     <= 1'b0;
    end else begin
      if (pend_v) begin
        tok.valid <= 1'b1;
        pend_v    <= new0_v;
      end else begin
        tok.valid <= new0_v;
        pend_v    <= new1_v;
      end
      if (in_valid && !is_blank) begin
        if (in_char == `FE_CH_NL) begin
          acc           <= '0;
          field_seen    <= 1'b0;
          at_line_start <= 1'b1;
        end else if (at_line_start) begin
          at_line_start <= 1'b0;
        end else if (in_char == `FE_CH_COMMA) begin
          acc        <= '0;
          field_seen <= 1'b0;
        end else if (is_data) begin
          // Six new low bits, oldest bits fall off the top
          acc        <= {acc[`FE_WORD_W-`FE_FIELD_W-1:0], in_char[`FE_FIELD_W-1:0]};
          field_seen <= 1'b1;
        end
      end
    end
  end

  // Payload follows the same ordering as valid
  always_ff @(posedge clk) begin
    if (pend_v) begin
      {tok.kind, tok.rtype_char, tok.word} <= pend;
      pend <= new0;
    end else begin
      {tok.kind, tok.rtype_char, tok.word} <= new0;
      pend <= new1;
    end
  end

endmodule

`default_nettype wire

/* credit_char_rx.sv */
// Character receive FIFO that drains every cycle and returns one credit per pop
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module credit_char_rx (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    char_valid,
  input  wire  [`FE_CHAR_W-1:0]  char_data,
  output logic                   out_valid,
  output logic [`FE_CHAR_W-1:0]  out_char,
  output logic                   char_credit
);

  localparam int PTR_W = $clog2(`FE_CREDITS);

  // Storage, one slot per outstanding credit
  logic [`FE_CHAR_W-1:0] mem [`FE_CREDITS];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Occupancy, one bit wider than the pointers so full is visible
  logic [PTR_W:0]   count;
  logic             pop;

  // Downstream always takes a character, so anything held leaves now
  assign pop       = (count != '0);
  assign out_valid = pop;
  assign out_char  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (char_valid) begin
      mem[wr_ptr] <= char_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      char_credit <= 1'b0;
    end else begin
      if (char_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({char_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Credit goes back the cycle after the slot frees up
      char_credit <= pop;
    end
  end

  // Sender honours the credit count, so a push never meets a full FIFO
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) char_valid |-> (count < `FE_CREDITS)
  ) else $error("credit_char_rx: write while full, count=%0d", count);

endmodule

`default_nettype wire

/* fe_consts.svh */
// Microcode loader constants for field widths, credit depth and character codes
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// Character stream and ASCIIized field widths
`define FE_CHAR_W      7
`define FE_FIELD_W     6
`define FE_WORD_W      16

// Receive FIFO depth, which is also the sender's starting credit count
`define FE_CREDITS     4

// RAM geometry
`define FE_CRAM_W      86
`define FE_CRAM_ADR_W  11
`define FE_DRAM_ADR_W  8

// Load file words per RAM write
`define FE_CRAM_GROUP  6
`define FE_DRAM_GROUP  3

// Separators
`define FE_CH_COMMA    7'o054
`define FE_CH_NL       7'o012
`define FE_CH_CR       7'o015
`define FE_CH_SPACE    7'o040

// Record type letters
`define FE_CH_C        7'h43
`define FE_CH_D        7'h44
`define FE_CH_SEMI     7'h3b

`endif

/* list.f */
+incdir+.
ucode_fmt_pkg.sv
load_stream_pkg.sv
load_token_if.sv
credit_char_rx.sv
ascii_field_decoder.sv
load_record_parser.sv
ucode_loader_top.sv
tb_ucode_loader.sv

/* load_record_parser.sv */
// Record FSM that builds RAM writes from tokens and checks each line's checksum
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module load_record_parser (
  input  wire                        clk,
  input  wire                        rst_n,
  load_token_if.sink                 tok,
  output logic                       cram_wr,
  output ucode_fmt_pkg::cram_adr_t   cram_adr,
  output ucode_fmt_pkg::cram_word_t  cram_data,
  output logic                       dram_wr,
  output ucode_fmt_pkg::dram_adr_t   dram_adr,
  output ucode_fmt_pkg::load_word_t  dram_even,
  output ucode_fmt_pkg::load_word_t  dram_odd,
  output ucode_fmt_pkg::load_word_t  dram_common,
  output logic                       rec_done,
  output logic                       rec_err
);

  load_stream_pkg::token_kind_e  kind;
  load_stream_pkg::parse_state_e state;
  load_stream_pkg::rec_type_e    rtype;

  // Position inside the current RAM word group
  logic [2:0]                grp;
  logic [2:0]                grp_last;
  logic                      grp_done;
  // Data words still expected before the checksum
  ucode_fmt_pkg::load_word_t remaining;
  // Running 16-bit sum, zero at EOL for a good line
  ucode_fmt_pkg::load_word_t sum;
  logic                      bad;
  logic                      wc_ragged;
  logic                      data_tok;
  // Next write address per RAM, kept across records for ADR = 0
  ucode_fmt_pkg::cram_adr_t  next_cadr;
  ucode_fmt_pkg::dram_adr_t  next_dadr;

  assign kind = load_stream_pkg::token_kind_e'(tok.kind);

  assign grp_last = (rtype == load_stream_pkg::REC_CRAM) ? 3'(`FE_CRAM_GROUP - 1)
                                                          : 3'(`FE_DRAM_GROUP - 1);

  // Word count must cover whole groups
  assign wc_ragged = (rtype == load_stream_pkg::REC_CRAM) ? ((tok.word % `FE_CRAM_GROUP) != 0)
                                                           : ((tok.word % `FE_DRAM_GROUP) != 0);

  assign data_tok = tok.valid && (kind != load_stream_pkg::TOK_EOL) &&
                    (state == load_stream_pkg::ST_DATA);
  assign grp_done = data_tok && (grp == grp_last);

  ////////////////////////////////////////
  // Record FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    cram_wr  <= 1'b0;
    dram_wr  <= 1'b0;
    rec_done <= 1'b0;
    rec_err  <= 1'b0;
    if (!rst_n) begin
      state     <= load_stream_pkg::ST_IDLE;
      rtype     <= load_stream_pkg::REC_NONE;
      grp       <= '0;
      remaining <= '0;
      sum       <= '0;
      bad       <= 1'b0;
      next_cadr <= '0;
      next_dadr <= '0;
    end else if (tok.valid && kind == load_stream_pkg::TOK_EOL) begin
      // Comment lines finish silently
      if (state != load_stream_pkg::ST_IDLE && rtype != load_stream_pkg::REC_NONE) begin
        rec_done <= 1'b1;
        rec_err  <= bad || (sum != '0) || (state != load_stream_pkg::ST_TAIL);
      end
      state <= load_stream_pkg::ST_IDLE;
    end else if (tok.valid) begin
      case (state)
        load_stream_pkg::ST_IDLE: begin
          if (kind == load_stream_pkg::TOK_TYPE) begin
            grp <= '0;
            sum <= '0;
            bad <= 1'b0;
            case (tok.rtype_char)
              `FE_CH_C: begin
                rtype <= load_stream_pkg::REC_CRAM;
                state <= load_stream_pkg::ST_WC;
              end
              `FE_CH_D: begin
                rtype <= load_stream_pkg::REC_DRAM;
                state <= load_stream_pkg::ST_WC;
              end
              `FE_CH_SEMI: begin
                rtype <= load_stream_pkg::REC_NONE;
                state <= load_stream_pkg::ST_SKIP;
              end
              default: begin
                // Unknown letter, flagged at end of line
                rtype <= load_stream_pkg::REC_SKIP;
                bad   <= 1'b1;
                state <= load_stream_pkg::ST_SKIP;
              end
            endcase
          end
        end
        load_stream_pkg::ST_WC: begin
          sum       <= tok.word;
          remaining <= tok.word;
          bad       <= wc_ragged;
          state     <= load_stream_pkg::ST_ADR;
        end
        load_stream_pkg::ST_ADR: begin
          sum <= sum + tok.word;
          // Zero address continues where the last record of this RAM stopped
          if (tok.word != '0) begin
            if (rtype == load_stream_pkg::REC_CRAM) begin
              next_cadr <= tok.word[`FE_CRAM_ADR_W-1:0];
            end else begin
              next_dadr <= tok.word[`FE_DRAM_ADR_W-1:0];
            end
          end
          state <= (remaining == '0) ? load_stream_pkg::ST_TAIL : load_stream_pkg::ST_DATA;
        end
        load_stream_pkg::ST_DATA: begin
          sum       <= sum + tok.word;
          remaining <= remaining - 1'b1;
          grp       <= grp_done ? '0 : grp + 1'b1;
          if (grp_done && rtype == load_stream_pkg::REC_CRAM) begin
            cram_wr   <= 1'b1;
            next_cadr <= next_cadr + 1'b1;
          end else if (grp_done) begin
            // Pairs of locations, so step by two
            dram_wr   <= 1'b1;
            next_dadr <= next_dadr + ucode_fmt_pkg::dram_adr_t'(2);
          end
          if (remaining == 1) begin
            state <= load_stream_pkg::ST_CKSUM;
          end
        end
        load_stream_pkg::ST_CKSUM: begin
          sum   <= sum + tok.word;
          state <= load_stream_pkg::ST_TAIL;
        end
        load_stream_pkg::ST_TAIL: begin
          // Anything after the checksum spoils the line
          bad <= 1'b1;
        end
        default: begin
          state <= state;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Word assembly
  ////////////////////////////////////////

  // Output registers double as assembly and even/odd holding registers
  always_ff @(posedge clk) begin
    if (data_tok && rtype == load_stream_pkg::REC_CRAM) begin
      case (grp)
        3'd0: cram_data[64:79] <= tok.word;
        3'd1: cram_data[48:63] <= tok.word;
        3'd2: cram_data[32:47] <= tok.word;
        3'd3: cram_data[16:31] <= tok.word;
        3'd4: cram_data[0:15]  <= tok.word;
        default: begin
          // CALL and DISP field from the low six bits
          cram_data[80:85] <= tok.word[`FE_FIELD_W-1:0];
          cram_adr         <= next_cadr;
        end
      endcase
    end else if (data_tok) begin
      case (grp)
        3'd0: dram_even <= tok.word;
        3'd1: dram_odd  <= tok.word;
        default: begin
          dram_common <= tok.word;
          dram_adr    <= next_dadr;
        end
      endcase
    end
  end

  // One token completes at most one group of one RAM type
  a_one_ram: assert property (
    @(posedge clk) disable iff (!rst_n) !(cram_wr && dram_wr)
  ) else $error("load_record_parser: cram_wr and dram_wr together");

  // Errors only come with a finished record
  a_err_done: assert property (
    @(posedge clk) disable iff (!rst_n) rec_err |-> rec_done
  ) else $error("load_record_parser: rec_err without rec_done");

endmodule

`default_nettype wire

/* load_stream_pkg.sv */
// Load stream types: decoder token kinds, record types and parser states
`default_nettype none

package load_stream_pkg;

  // Tokens leaving the field decoder
  typedef enum logic [1:0] {
    TOK_TYPE,  // First character of a line
    TOK_WORD,  // Field closed by comma or newline
    TOK_EOL    // Newline
  } token_kind_e;

  // Record being parsed
  typedef enum logic [1:0] {
    REC_NONE,  // Comment line, reports nothing
    REC_CRAM,  // C record
    REC_DRAM,  // D record
    REC_SKIP   // Unknown letter, reported bad at end of line
  } rec_type_e;

  // Parser FSM
  typedef enum logic [2:0] {
    ST_IDLE,   // Waiting for a type token
    ST_WC,     // Expecting the word count
    ST_ADR,    // Expecting the start address
    ST_DATA,   // Data words, grouped per RAM write
    ST_CKSUM,  // Expecting the negated checksum
    ST_TAIL,   // Record complete, only EOL expected
    ST_SKIP    // Discard words up to EOL
  } parse_state_e;

endpackage

`default_nettype wire

/* load_token_if.sv */
// Token channel from the ASCIIized field decoder to the record parser
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

interface load_token_if;

  // One token per cycle while high, sink never stalls
  logic                  valid;
  // Token kind, same encoding as the load stream token enum
  logic [1:0]            kind;
  // Line's first character, meaningful for type tokens
  logic [`FE_CHAR_W-1:0] rtype_char;
  // Decoded field, meaningful for word tokens
  logic [`FE_WORD_W-1:0] word;

  // Decoder side
  modport source (output valid, kind, rtype_char, word);

  // Parser side
  modport sink (input valid, kind, rtype_char, word);

endinterface

`default_nettype wire

/* tb_ucode_loader.sv */
// Testbench for the microcode loader front end with credited character stimulus and RAM write checks
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module tb_ucode_loader;

  logic                      clk;
  logic                      rst_n;
  logic                      char_valid;
  logic [`FE_CHAR_W-1:0]     char_data;
  logic                      char_credit;
  logic                      cram_wr;
  ucode_fmt_pkg::cram_adr_t  cram_adr;
  ucode_fmt_pkg::cram_word_t cram_data;
  logic                      dram_wr;
  ucode_fmt_pkg::dram_adr_t  dram_adr;
  ucode_fmt_pkg::load_word_t dram_even;
  ucode_fmt_pkg::load_word_t dram_odd;
  ucode_fmt_pkg::load_word_t dram_common;
  logic                      rec_done;
  logic                      rec_err;

  // Character stream and expected results built before the run
  logic [`FE_CHAR_W-1:0]                    stream_q [$];
  logic [`FE_CRAM_ADR_W+`FE_CRAM_W-1:0]     cram_q [$];
  logic [`FE_DRAM_ADR_W+3*`FE_WORD_W-1:0]   dram_q [$];
  logic                                     done_q [$];

  // Head of each queue refreshed on the falling edge
  ucode_fmt_pkg::cram_adr_t  exp_cram_adr;
  ucode_fmt_pkg::cram_word_t exp_cram_data;
  ucode_fmt_pkg::dram_adr_t  exp_dram_adr;
  ucode_fmt_pkg::load_word_t exp_dram_even;
  ucode_fmt_pkg::load_word_t exp_dram_odd;
  ucode_fmt_pkg::load_word_t exp_dram_common;
  logic                      exp_err;
  int                        cram_left;
  int                        dram_left;
  int                        done_left;

  // Sender side credit bookkeeping
  int sent_cnt;
  int ret_cnt;
  int credits;
  int total_chars;
  int seed;
  // High once the stream has drained and all credits should be home
  logic idle;
  // Model of the next address per RAM
  ucode_fmt_pkg::cram_adr_t c_next;
  ucode_fmt_pkg::dram_adr_t d_next;

  assign credits = `FE_CREDITS - sent_cnt + ret_cnt;

  ucode_loader_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .char_valid  (char_valid),
    .char_data   (char_data),
    .char_credit (char_credit),
    .cram_wr     (cram_wr),
    .cram_adr    (cram_adr),
    .cram_data   (cram_data),
    .dram_wr     (dram_wr),
    .dram_adr    (dram_adr),
    .dram_even   (dram_even),
    .dram_odd    (dram_odd),
    .dram_common (dram_common),
    .rec_done    (rec_done),
    .rec_err     (rec_err)
  );

  // 8 ns period
  always begin
    #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_n && char_credit) begin
      ret_cnt <= ret_cnt + 1;
    end
  end

  // Outputs seen at this edge retire the head of their queue
  always @(posedge clk) begin
    if (rst_n && cram_wr && cram_q.size() > 0) begin
      void'(cram_q.pop_front());
    end
    if (rst_n && dram_wr && dram_q.size() > 0) begin
      void'(dram_q.pop_front());
    end
    if (rst_n && rec_done && done_q.size() > 0) begin
      void'(done_q.pop_front());
    end
  end

  always @(negedge clk) begin
    cram_left = cram_q.size();
    dram_left = dram_q.size();
    done_left = done_q.size();
    if (cram_left > 0) begin
      {exp_cram_adr, exp_cram_data} = cram_q[0];
    end
    if (dram_left > 0) begin
      {exp_dram_adr, exp_dram_even, exp_dram_odd, exp_dram_common} = dram_q[0];
    end
    if (done_left > 0) begin
      exp_err = done_q[0];
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
    (credits >= 0) && (credits <= `FE_CREDITS))
    else report_failure($sformatf("** Error: credits = %h, allowed 0 to %h",
                                  $sampled(credits), `FE_CREDITS));
  a_credit_idle: assert property (@(posedge clk) disable iff (!rst_n)
    idle |-> (credits == `FE_CREDITS))
    else report_failure($sformatf("** Error: credits = %h at idle, expected %h",
                                  $sampled(credits), `FE_CREDITS));

  a_cram_expected: assert property (@(posedge clk) disable iff (!rst_n)
    cram_wr |-> (cram_left > 0))
    else report_failure("Control-RAM write seen with none expected");
  a_cram_adr: assert property (@(posedge clk) disable iff (!rst_n)
    (cram_wr && cram_left > 0) |-> (cram_adr == exp_cram_adr))
    else report_failure($sformatf("** Error: cram_adr = %h, expected %h",
                                  $sampled(cram_adr), $sampled(exp_cram_adr)));
  a_cram_data: assert property (@(posedge clk) disable iff (!rst_n)
    (cram_wr && cram_left > 0) |-> (cram_data == exp_cram_data))
    else report_failure($sformatf("** Error: cram_data = %h, expected %h",
                                  $sampled(cram_data), $sampled(exp_cram_data)));

  a_dram_expected: assert property (@(posedge clk) disable iff (!rst_n)
    dram_wr |-> (dram_left > 0))
    else report_failure("Dispatch-RAM write seen with none expected");
  a_dram_adr: assert property (@(posedge clk) disable iff (!rst_n)
    (dram_wr && dram_left > 0) |-> (dram_adr == exp_dram_adr))
    else report_failure($sformatf("** Error: dram_adr = %h, expected %h",
                                  $sampled(dram_adr), $sampled(exp_dram_adr)));
  a_dram_even: assert property (@(posedge clk) disable iff (!rst_n)
    (dram_wr && dram_left > 0) |-> (dram_even == exp_dram_even))
    else report_failure($sformatf("** Error: dram_even = %h, expected %h",
                                  $sampled(dram_even), $sampled(exp_dram_even)));
  a_dram_odd: assert property (@(posedge clk) disable iff (!rst_n)
    (dram_wr && dram_left > 0) |-> (dram_odd == exp_dram_odd))
    else report_failure($sformatf("** Error: dram_odd = %h, expected %h",
                                  $sampled(dram_odd), $sampled(exp_dram_odd)));
  a_dram_common: assert property (@(posedge clk) disable iff (!rst_n)
    (dram_wr && dram_left > 0) |-> (dram_common == exp_dram_common))
    else report_failure($sformatf("** Error: dram_common = %h, expected %h",
                                  $sampled(dram_common), $sampled(exp_dram_common)));

  a_done_expected: assert property (@(posedge clk) disable iff (!rst_n)
    rec_done |-> (done_left > 0))
    else report_failure("Record completion seen with no record pending");
  a_rec_err: assert property (@(posedge clk) disable iff (!rst_n)
    (rec_done && done_left > 0) |-> (rec_err == exp_err))
    else report_failure($sformatf("** Error: rec_err = %h, expected %h",
                                  $sampled(rec_err), $sampled(exp_err)));
  a_err_needs_done: assert property (@(posedge clk) disable iff (!rst_n)
    rec_err |-> rec_done)
    else report_failure("Record error raised without record completion");

  ////////////////////////////////////////
  // Stimulus building
  ////////////////////////////////////////

  // Six-bit value to its load file character
  function automatic logic [`FE_CHAR_W-1:0] field_char(input logic [`FE_FIELD_W-1:0] g);
    if (g < 6'o75) begin
      return {1'b1, g};
    end else begin
      return {1'b0, g};
    end
  endfunction

  task automatic put_char(input logic [`FE_CHAR_W-1:0] c);
    stream_q.push_back(c);
  endtask

  // Three characters with the top four bits first
  task automatic put_word(input ucode_fmt_pkg::load_word_t w);
    put_char(field_char({2'b00, w[15:12]}));
    put_char(field_char(w[11:6]));
    put_char(field_char(w[5:0]));
  endtask

  task automatic put_text(input string s);
    byte ch;
    for (int i = 0; i < s.len(); i++) begin
      ch = s[i];
      put_char(ch[`FE_CHAR_W-1:0]);
    end
  endtask

  task automatic put_line_end();
    put_char(`FE_CH_CR);
    put_char(`FE_CH_NL);
  endtask

  // C or D record of whole groups where adr 0 continues and 0 groups gives ",,"
  task automatic add_record(input logic [`FE_CHAR_W-1:0] rtype, input int groups,
                            input ucode_fmt_pkg::load_word_t adr, input bit corrupt);
    ucode_fmt_pkg::load_word_t grp_w [`FE_CRAM_GROUP];
    ucode_fmt_pkg::load_word_t sum;
    ucode_fmt_pkg::cram_word_t cw;
    int gsize;
    int n;
    gsize = (rtype == `FE_CH_C) ? `FE_CRAM_GROUP : `FE_DRAM_GROUP;
    n     = groups * gsize;
    put_char(rtype);
    put_char(`FE_CH_SPACE);
    if (n == 0) begin
      put_char(`FE_CH_COMMA);
      put_char(`FE_CH_COMMA);
    end else begin
      put_word(16'(n));
      put_char(`FE_CH_COMMA);
      // Empty field stands for address zero
      if (adr != 0) begin
        put_word(adr);
        if (rtype == `FE_CH_C) begin
          c_next = adr[`FE_CRAM_ADR_W-1:0];
        end else begin
          d_next = adr[`FE_DRAM_ADR_W-1:0];
        end
      end
      put_char(`FE_CH_COMMA);
      sum = 16'(n) + adr;
      for (int k = 0; k < n; k++) begin
        grp_w[k % gsize] = 16'($random(seed));
        sum = sum + grp_w[k % gsize];
        put_word(grp_w[k % gsize]);
        put_char(`FE_CH_COMMA);
        if (k % gsize == gsize - 1) begin
          if (rtype == `FE_CH_C) begin
            cw        = '0;
            cw[64:79] = grp_w[0];
            cw[48:63] = grp_w[1];
            cw[32:47] = grp_w[2];
            cw[16:31] = grp_w[3];
            cw[0:15]  = grp_w[4];
            cw[80:85] = grp_w[5][5:0];
            cram_q.push_back({c_next, cw});
            c_next = c_next + 1'b1;
          end else begin
            dram_q.push_back({d_next, grp_w[0], grp_w[1], grp_w[2]});
            d_next = d_next + 8'd2;
          end
        end
      end
      // Negated sum that is off by one when corrupted
      put_word(corrupt ? 16'h0001 - sum : 16'h0000 - sum);
    end
    put_line_end();
    done_q.push_back(corrupt);
  endtask

  // Sends 1 ns after the edge once a credit is held
  task automatic send_char(input logic [`FE_CHAR_W-1:0] c);
    while (credits == 0) begin
      char_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    char_valid = 1'b1;
    char_data  = c;
    sent_cnt   = sent_cnt + 1;
    @(posedge clk);
    #1;
    char_valid = 1'b0;
  endtask

  initial begin : watchdog
    wait (total_chars > 0);
    repeat (total_chars * 20 + 200) @(posedge clk);
    $display("Timeout: loader did not finish within %0d cycles", total_chars * 20 + 200);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    char_valid  = 1'b0;
    char_data   = '0;
    sent_cnt    = 0;
    ret_cnt     = 0;
    total_chars = 0;
    seed        = 32'h790;
    idle        = 1'b0;
    c_next      = '0;
    d_next      = '0;

    add_record(`FE_CH_C, 2, 16'd100, 1'b0);
    add_record(`FE_CH_D, 3, 16'd40, 1'b0);
    put_text("; dispatch table follows");
    put_line_end();
    add_record(`FE_CH_C, 1, 16'd0, 1'b0);
    add_record(`FE_CH_D, 2, 16'd0, 1'b0);
    add_record(`FE_CH_C, 0, 16'd0, 1'b0);
    add_record(`FE_CH_C, 1, 16'd200, 1'b1);
    // Unknown record letter
    put_text("X 12,34");
    put_line_end();
    done_q.push_back(1'b1);
    add_record(`FE_CH_D, 1, 16'd0, 1'b0);
    total_chars = stream_q.size();

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (stream_q[i]) begin
      send_char(stream_q[i]);
    end

    while (cram_q.size() > 0 || dram_q.size() > 0 || done_q.size() > 0) begin
      @(posedge clk);
    end
    // Room for any stray strobe to show up
    repeat (8) @(posedge clk);
    #1;
    idle = 1'b1;
    // One edge for the idle credit check to sample
    @(posedge clk);
    #1;
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* ucode_fmt_pkg.sv */
// Control-RAM and dispatch-RAM word and address types for the microcode loader
`default_nettype none

`include "fe_consts.svh"

package ucode_fmt_pkg;

  ////////////////////////////////////////
  // Control RAM
  ////////////////////////////////////////

  // Numbered as in the hardware, bit 0 is the most significant
  // Load file supplies 64-79, 48-63, 32-47, 16-31, 0-15, then 80-85
  typedef logic [0:`FE_CRAM_W-1] cram_word_t;

  // Control-RAM location
  typedef logic [`FE_CRAM_ADR_W-1:0] cram_adr_t;

  ////////////////////////////////////////
  // Dispatch RAM
  ////////////////////////////////////////

  // Addresses even locations of an even/odd pair
  // Steps by two per written pair
  typedef logic [`FE_DRAM_ADR_W-1:0] dram_adr_t;

  ////////////////////////////////////////
  // Load file
  ////////////////////////////////////////

  // One decoded PDP-11 style word from the load file
  typedef logic [`FE_WORD_W-1:0] load_word_t;

endpackage

`default_nettype wire

/* ucode_loader_top.sv */
// Microcode loader front end from credited character input to RAM write strobes
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module ucode_loader_top (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        char_valid,
  input  wire  [`FE_CHAR_W-1:0]      char_data,
  output logic                       char_credit,
  output logic                       cram_wr,
  output ucode_fmt_pkg::cram_adr_t   cram_adr,
  output ucode_fmt_pkg::cram_word_t  cram_data,
  output logic                       dram_wr,
  output ucode_fmt_pkg::dram_adr_t   dram_adr,
  output ucode_fmt_pkg::load_word_t  dram_even,
  output ucode_fmt_pkg::load_word_t  dram_odd,
  output ucode_fmt_pkg::load_word_t  dram_common,
  output logic                       rec_done,
  output logic                       rec_err
);

  // FIFO to decoder, one character per cycle
  logic                  rx_valid;
  logic [`FE_CHAR_W-1:0] rx_char;

  // Decoder to parser token channel
  load_token_if tok_if ();

  credit_char_rx rx_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .char_valid  (char_valid),
    .char_data   (char_data),
    .out_valid   (rx_valid),
    .out_char    (rx_char),
    .char_credit (char_credit)
  );

  ascii_field_decoder dec_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (rx_valid),
    .in_char  (rx_char),
    .tok      (tok_if.source)
  );

  load_record_parser parse_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .tok         (tok_if.sink),
    .cram_wr     (cram_wr),
    .cram_adr    (cram_adr),
    .cram_data   (cram_data),
    .dram_wr     (dram_wr),
    .dram_adr    (dram_adr),
    .dram_even   (dram_even),
    .dram_odd    (dram_odd),
    .dram_common (dram_common),
    .rec_done    (rec_done),
    .rec_err     (rec_err)
  );

endmodule

`default_nettype wire
